//--- Makefile
.PHONY: all compile run clean

TOP := tb_bp

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) | tee run.log
	@grep -q "^TB PASSED" run.log && echo "simulation passed" || \
		(echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir run.log

//--- bp_pkg.sv
package bp_pkg;

    parameter int xlen = 32;

    // fetch restarts here on an exception
    parameter logic [xlen-1:0] trap_vec = 32'h0000_0080;

    typedef enum logic [1:0] {
        br_none,
        br_cond,
        br_jal,
        br_jalr
    } br_kind_e;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, seen as B-type or J-type
    typedef union packed {
        logic [31:0] raw;
        b_fmt_t      b_fmt;
        j_fmt_t      j_fmt;
    } inst_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_u           inst;
    } fetch_t;

    typedef struct packed {
        br_kind_e        kind;
        logic [4:0]      rs1;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
    } dec_t;

    // branch outcome leaving EX
    typedef struct packed {
        logic            valid;
        logic            is_cond;
        logic [xlen-1:0] pc;
        logic            taken;
        logic            pred_taken;
        logic [xlen-1:0] pred_pc;   // next pc fetch actually used
        logic [xlen-1:0] actual_pc; // correct next pc
    } resolve_t;

endpackage

//--- bp_top.sv
`timescale 1ns/1ps

module bp_top import bp_pkg::*; #(
    parameter int PHT_BITS = 8,
    parameter int RAS_BITS = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            excp,
    input  fetch_t          fetch,
    input  resolve_t        resolve,
    output logic [xlen-1:0] next_pc,
    output logic            pred_taken,
    output logic            mispredict,
    output logic [xlen-1:0] sepc
);

    dec_t            dec;
    logic [1:0]      counter;
    logic [xlen-1:0] top_addr;
    logic            train_en;
    logic            push;
    logic            pop;

    inst_decode u_decode (
        .fetch (fetch),
        .dec   (dec)
    );

    // indexed by word address, low two bits dropped
    pht #(
        .PHT_BITS (PHT_BITS)
    ) u_pht (
        .clk         (clk),
        .rst         (rst),
        .read_idx    (fetch.pc[PHT_BITS+1:2]),
        .train_en    (train_en),
        .train_idx   (resolve.pc[PHT_BITS+1:2]),
        .train_taken (resolve.taken),
        .counter     (counter)
    );

    ras #(
        .RAS_BITS (RAS_BITS)
    ) u_ras (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pop       (pop),
        .push_addr (fetch.pc + 32'd4), // return address
        .top_addr  (top_addr)
    );

    redirect_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .excp       (excp),
        .fetch      (fetch),
        .dec        (dec),
        .resolve    (resolve),
        .counter    (counter),
        .top_addr   (top_addr),
        .next_pc    (next_pc),
        .pred_taken (pred_taken),
        .mispredict (mispredict),
        .sepc       (sepc),
        .train_en   (train_en),
        .push       (push),
        .pop        (pop)
    );

endmodule

//--- bp_vectors.txt
# stall excp pc inst  resolve: valid is_cond pc taken pred_taken pred_pc actual_pc
# expected: next_pc pred_taken mispredict sepc   (all fields hex, one line per cycle)
0 0 00000100 100000ef 1 0 00000300 1 1 00000400 00000500 00000000 0 0 00000000
0 0 00000000 003100b3 0 0 00000000 0 0 00000000 00000000 00000004 0 0 00000000
0 0 00000004 003100b3 0 0 00000000 0 0 00000000 00000000 00000008 0 0 00000000
0 0 00000040 00000863 0 0 00000000 0 0 00000000 00000000 00000044 0 0 00000000
0 0 00000008 003100b3 1 1 00000040 1 1 00000050 00000050 0000000c 0 0 00000000
0 0 0000000c 003100b3 1 1 00000040 1 1 00000050 00000050 00000010 0 0 00000000
0 0 00000040 00000863 1 1 00000040 1 1 00000050 00000050 00000050 1 0 00000000
0 0 00000010 003100b3 1 1 00000040 0 0 00000044 00000044 00000014 0 0 00000000
0 0 00000040 00000863 1 1 00000040 0 0 00000044 00000044 00000050 1 0 00000000
0 0 00000040 00000863 1 1 00000040 0 0 00000044 00000044 00000044 0 0 00000000
0 0 00000014 003100b3 1 1 00000040 0 0 00000044 00000044 00000018 0 0 00000000
0 0 00000018 003100b3 1 1 00000040 1 1 00000050 00000050 0000001c 0 0 00000000
0 0 00000040 00000863 1 1 00000040 1 1 00000050 00000050 00000044 0 0 00000000
0 0 00000040 00000863 0 0 00000000 0 0 00000000 00000000 00000050 1 0 00000000
0 0 00000100 100000ef 0 0 00000000 0 0 00000000 00000000 00000200 1 0 00000000
0 0 00000200 200000ef 0 0 00000000 0 0 00000000 00000000 00000400 1 0 00000000
0 0 00000400 003100b3 0 0 00000000 0 0 00000000 00000000 00000404 0 0 00000000
0 0 00000404 00008067 0 0 00000000 0 0 00000000 00000000 00000204 1 0 00000000
0 0 00000204 00008067 0 0 00000000 0 0 00000000 00000000 00000104 1 0 00000000
0 0 00000104 00828067 0 0 00000000 0 0 00000000 00000000 0000010c 1 0 00000000
0 0 0000010c 1000006f 0 0 00000000 0 0 00000000 00000000 0000020c 1 0 00000000
0 0 0000020c 100000ef 0 0 00000000 0 0 00000000 00000000 0000030c 1 0 00000000
1 0 0000030c 00008067 0 0 00000000 0 0 00000000 00000000 00000210 1 0 00000000
0 0 0000030c 00008067 0 0 00000000 0 0 00000000 00000000 00000210 1 0 00000000
0 0 00000060 00000863 1 1 00000040 1 0 00000044 00000050 00000050 1 1 00000000
0 0 00000100 100000ef 1 0 00000300 1 1 00000400 00000204 00000204 1 1 00000000
0 0 00000050 003100b3 1 0 00000100 1 1 00000200 00000200 00000054 0 0 00000000
0 1 00000054 003100b3 0 0 00000000 0 0 00000000 00000000 00000080 0 0 00000000
0 0 00000080 003100b3 0 0 00000000 0 0 00000000 00000000 00000084 0 0 00000058
0 1 00000084 003100b3 1 0 00000300 1 1 00000400 00000500 00000080 0 1 00000058
1 1 00000200 003100b3 0 0 00000000 0 0 00000000 00000000 00000080 0 0 00000088
0 0 00000088 003100b3 0 0 00000000 0 0 00000000 00000000 0000008c 0 0 00000204
1 0 0000008c 003100b3 1 1 00000060 1 1 00000070 00000070 00000090 0 0 00000204
0 0 00000060 00000863 0 0 00000000 0 0 00000000 00000000 00000064 0 0 00000204
0 0 00000064 003100b3 1 1 00000060 1 1 00000070 00000070 00000068 0 0 00000204
0 0 00000060 00000863 0 0 00000000 0 0 00000000 00000000 00000070 1 0 00000204

//--- inst_decode.sv
`timescale 1ns/1ps

module inst_decode import bp_pkg::*; (
    input  fetch_t fetch,
    output dec_t   dec
);

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    inst_u           word;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_i;

    assign word = fetch.inst;

    // B-type offset, bit 0 always zero
    assign imm_b = {{20{word.b_fmt.imm12}},
                    word.b_fmt.imm11,
                    word.b_fmt.imm10_5,
                    word.b_fmt.imm4_1,
                    1'b0};

    // J-type offset, same word read through the other view
    assign imm_j = {{12{word.j_fmt.imm20}},
                    word.j_fmt.imm19_12,
                    word.j_fmt.imm11,
                    word.j_fmt.imm10_1,
                    1'b0};

    assign imm_i = {{20{word.raw[31]}}, word.raw[31:20]}; // jalr offset

    always_comb begin
        dec.rs1 = word.b_fmt.rs1;
        dec.rd  = word.j_fmt.rd;
        unique case (word.raw[6:0])
            op_branch: begin
                dec.kind = br_cond;
                dec.imm  = imm_b;
            end
            op_jal: begin
                dec.kind = br_jal;
                dec.imm  = imm_j;
            end
            op_jalr: begin
                dec.kind = br_jalr;
                dec.imm  = imm_i;
            end
            default: begin
                dec.kind = br_none;
                dec.imm  = '0; // not a control transfer
            end
        endcase
    end

endmodule

//--- pht.sv
`timescale 1ns/1ps

module pht #(
    parameter int PHT_BITS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [PHT_BITS-1:0] read_idx,
    input  logic                train_en,
    input  logic [PHT_BITS-1:0] train_idx,
    input  logic                train_taken,
    output logic [1:0]          counter
);

    localparam int pht_depth = 2 ** PHT_BITS;

    // 0 strong not-taken .. 3 strong taken
    logic [1:0] table_q [pht_depth];
    logic [1:0] cur;

    assign counter = table_q[read_idx]; // async read for fetch
    assign cur     = table_q[train_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pht_depth; i++) begin
                table_q[i] <= 2'd1; // weakly not-taken
            end
        end else if (train_en) begin
            if (train_taken) begin
                if (cur != 2'd3) begin
                    table_q[train_idx] <= cur + 2'd1;
                end
            end else begin
                if (cur != 2'd0) begin
                    table_q[train_idx] <= cur - 2'd1;
                end
            end
        end
    end

endmodule

//--- ras.sv
`timescale 1ns/1ps

module ras import bp_pkg::*; #(
    parameter int RAS_BITS = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic            pop,
    input  logic [xlen-1:0] push_addr,
    output logic [xlen-1:0] top_addr
);

    localparam int ras_depth = 2 ** RAS_BITS;

    logic [xlen-1:0]     stack_q [ras_depth];
    logic [RAS_BITS-1:0] top_q;
    logic [RAS_BITS-1:0] top_inc;
    logic [RAS_BITS-1:0] top_dec;

    assign top_inc  = top_q + 1'b1; // wraps, oldest entry gets overwritten
    assign top_dec  = top_q - 1'b1;
    assign top_addr = stack_q[top_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            top_q <= '0;
        end else if (push) begin
            top_q <= top_inc;
        end else if (pop) begin
            top_q <= top_dec;
        end
    end

    // entries themselves carry no reset
    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[top_inc] <= push_addr;
        end
    end

endmodule

//--- redirect_ctrl.sv
`timescale 1ns/1ps

module redirect_ctrl import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            excp,
    input  fetch_t          fetch,
    input  dec_t            dec,
    input  resolve_t        resolve,
    input  logic [1:0]      counter,
    input  logic [xlen-1:0] top_addr,
    output logic [xlen-1:0] next_pc,
    output logic            pred_taken,
    output logic            mispredict,
    output logic [xlen-1:0] sepc,
    output logic            train_en,
    output logic            push,
    output logic            pop
);

    logic            start_q; // low in reset and the cycle after it
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_imm;
    logic            is_jump;
    logic            is_call;
    logic            is_ret;
    logic            ras_ok;

    assign pc_plus4 = fetch.pc + 32'd4;
    assign pc_imm   = fetch.pc + dec.imm;

    assign is_jump = (dec.kind == br_jal) || (dec.kind == br_jalr);
    assign is_call = is_jump && (dec.rd == 5'd1);
    assign is_ret  = (dec.kind == br_jalr) && (dec.rs1 == 5'd1) && (dec.rd != 5'd1);

    // EX saw a different next pc than fetch used
    assign mispredict = start_q && resolve.valid && (resolve.pred_pc != resolve.actual_pc);

    assign train_en = resolve.valid && resolve.is_cond && !stall;

    assign ras_ok = start_q && !stall && !excp && !mispredict;
    assign push   = ras_ok && is_call;
    assign pop    = ras_ok && is_ret;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b1;
        end
    end

    // exception return address, taken even under stall
    always_ff @(posedge clk) begin
        if (rst) begin
            sepc <= '0;
        end else if (excp) begin
            sepc <= pc_plus4;
        end
    end

    always_comb begin
        next_pc    = pc_plus4;
        pred_taken = 1'b0;
        if (!start_q) begin
            next_pc = '0;
        end else if (excp) begin
            next_pc = trap_vec;
        end else if (mispredict) begin
            next_pc    = resolve.actual_pc;
            pred_taken = resolve.taken;
        end else begin
            unique case (dec.kind)
                br_jal: begin
                    next_pc    = pc_imm;
                    pred_taken = 1'b1;
                end
                br_jalr: begin
                    next_pc    = is_ret ? top_addr : pc_imm; // rs1 value not known here
                    pred_taken = 1'b1;
                end
                br_cond: begin
                    pred_taken = counter[1]; // 2 or 3 means taken
                    next_pc    = counter[1] ? pc_imm : pc_plus4;
                end
                default: begin
                    next_pc    = pc_plus4;
                    pred_taken = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- sim.f
bp_pkg.sv
inst_decode.sv
pht.sv
ras.sv
redirect_ctrl.sv
bp_top.sv
tb_bp.sv

//--- tb_bp.sv
`timescale 1ns/1ps

module tb_bp import bp_pkg::*; ();

    localparam int reset_cycles   = 8;
    localparam int timeout_margin = 20;

    // stimulus then expected outputs of one vectors line
    typedef struct packed {
        logic            stall;
        logic            excp;
        fetch_t          fetch;
        resolve_t        resolve;
        logic [xlen-1:0] next_pc;
        logic            pred_taken;
        logic            mispredict;
        logic [xlen-1:0] sepc;
    } vec_t;

    logic            clk;
    logic            rst;
    logic            stall;
    logic            excp;
    fetch_t          fetch;
    resolve_t        resolve;
    logic [xlen-1:0] next_pc;
    logic            pred_taken;
    logic            mispredict;
    logic [xlen-1:0] sepc;

    vec_t vecs[$];
    int   cur_vec;
    int   cycles;
    int   cycle_limit;

    bp_top #(
        .PHT_BITS (8),
        .RAS_BITS (3)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .excp       (excp),
        .fetch      (fetch),
        .resolve    (resolve),
        .next_pc    (next_pc),
        .pred_taken (pred_taken),
        .mispredict (mispredict),
        .sepc       (sepc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends a hung run once the limit is set
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run hung", cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic load_vectors(output string err);
        int              fd;
        int              nf;
        int              line_no;
        string           line;
        logic [xlen-1:0] pc_v, inst_v, rpc, rppc, rapc, e_next, e_sepc;
        logic            s_v, x_v, rv, rc, rt, rpt, e_pt, e_mp;
        vec_t            v;
        err = "";
        fd  = $fopen("bp_vectors.txt", "r");
        if (fd == 0) begin
            err = "could not open bp_vectors.txt, there is no stimulus to run";
        end else begin
            line_no = 0;
            while (!$feof(fd) && err == "") begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                nf = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             s_v, x_v, pc_v, inst_v, rv, rc, rpc, rt, rpt, rppc, rapc,
                             e_next, e_pt, e_mp, e_sepc);
                if (nf == 15) begin
                    // file columns follow the vec_t field order
                    v = {s_v, x_v, pc_v, inst_v, rv, rc, rpc, rt, rpt, rppc, rapc,
                         e_next, e_pt, e_mp, e_sepc};
                    vecs.push_back(v);
                end else if (nf > 0) begin
                    err = $sformatf("line %0d of bp_vectors.txt has %0d fields", line_no, nf);
                end
            end
            $fclose(fd);
            if (err == "" && vecs.size() == 0) begin
                err = "bp_vectors.txt holds no vectors";
            end
        end
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL t=%0t vector %0d %s", $time, cur_vec, msg);
        $display("TB FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                            input string name);
        if (got !== exp) begin
            report_fail($sformatf("%s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_fail($sformatf("%s got %b expected %b", name, got, exp));
        end
    endtask

    task automatic apply_vector(input vec_t v);
        stall   <= v.stall;
        excp    <= v.excp;
        fetch   <= v.fetch;
        resolve <= v.resolve;
    endtask

    task automatic run_vectors();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0; // first vector lands in the cycle after reset
        for (int i = 0; i < vecs.size(); i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            cur_vec = i;
            apply_vector(vecs[i]);
            @(negedge clk); // outputs settled before the next edge
            check_pc(next_pc, vecs[i].next_pc, "next_pc");
            check_bit(pred_taken, vecs[i].pred_taken, "pred_taken");
            check_bit(mispredict, vecs[i].mispredict, "mispredict");
            check_pc(sepc, vecs[i].sepc, "sepc");
        end
    endtask

    initial begin : main
        string load_err;
        rst         <= 1'b1;
        stall       <= 1'b0;
        excp        <= 1'b0;
        fetch       <= '0;
        resolve     <= '0;
        cur_vec     = 0;
        cycle_limit = 0;
        load_vectors(load_err);
        if (load_err != "") begin
            $display("%s", load_err);
            $display("TB FAILED");
            $fatal(1, "vectors file");
        end else begin
            cycle_limit = vecs.size() + reset_cycles + timeout_margin;
            run_vectors();
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
